// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = dev_rtc_tb
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: rtl/dev_rtc.sv
// RTC on the Z80 I/O bus; no wait states, one port pair, reads are valid in the cycle they are asked
`timescale 1ns/1ps

module dev_rtc (
    input  logic                    clk,
    input  logic                    rst,
    input  msx_rtc_pkg::cpu_bus_t   bus,
    input  msx_rtc_pkg::io_device_t io_device,
    input  logic                    ce_10hz,
    input  msx_rtc_pkg::rtc_time_t  rtc_time,
    output logic [7:0]              data
);

    logic                      io_cycle;
    logic                      port_hit;
    logic                      selected;
    logic                      wr_req;
    logic [3:0]                rd_nibble;
    logic                      run;
    msx_rtc_pkg::time_wr_t     time_wr;
    msx_rtc_pkg::time_nibble_t now;

    // An I/O cycle is iorq without m1, which rules out interrupt acknowledge
    assign io_cycle = bus.iorq && !bus.m1;

    // The mask drops address bit 0 so both ports of the pair match
    assign port_hit = (bus.addr[7:0] & io_device.mask) == io_device.port;
    assign selected = io_device.enable && port_hit && io_cycle;

    // Writes need the request strobe and the write flag during a selected cycle
    assign wr_req = selected && bus.req && bus.wr;

    // Upper nibble reads as ones, an unselected cycle leaves the bus all ones
    assign data = selected ? {msx_rtc_pkg::nibble_pad, rd_nibble} : 8'hFF;

    rtc_register_file regs0 (
        .clk      (clk),
        .rst      (rst),
        .req      (wr_req),
        .sel_data (bus.addr[0]),
        .wdata    (bus.wdata[3:0]),
        .now      (now),
        .time_wr  (time_wr),
        .run      (run),
        .rdata    (rd_nibble)
    );

    // Reset doubles as the setup load from the host time
    rtc_time_counter time0 (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .ce_10hz   (ce_10hz),
        .load_time (rtc_time),
        .time_wr   (time_wr),
        .now       (now)
    );

    // An interrupt acknowledge cycle never disturbs the address latch or mode register
    m1_no_write: assert property (@(posedge clk) disable iff (rst)
        bus.m1 |=> $stable(regs0.addr_q) && $stable(regs0.mode_q));

endmodule

// File: rtl/msx_rtc_pkg.sv
// Shared RTC types and constants; all time fields are packed BCD and the bus struct has no clock
package msx_rtc_pkg;

    // One CPU I/O cycle as the RTC wrapper sees it (28 bits)
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        iorq;
        logic        m1;
        logic        req;
        logic        wr;
    } cpu_bus_t;

    // Port configuration, the port value is expected with bit 0 clear (17 bits)
    typedef struct packed {
        logic       enable;
        logic [7:0] port;
        logic [7:0] mask;
    } io_device_t;

    // Host time in BCD, update requests a load into the counter (57 bits)
    typedef struct packed {
        logic [7:0] year;
        logic [7:0] month;
        logic [7:0] day;
        logic [7:0] wday;
        logic [7:0] hour;
        logic [7:0] min;
        logic [7:0] sec;
        logic       update;
    } rtc_time_t;

    // Single digit write from the register file into the time counter (9 bits)
    typedef struct packed {
        logic       valid;
        logic [3:0] index;
        logic [3:0] value;
    } time_wr_t;

    // Mode register address and its value after reset (timer on, block 0)
    localparam logic [3:0] reg_mode         = 4'd13;
    localparam logic [3:0] mode_reset_value = 4'd8;

    // Nibbles per block and the pad used for the upper half of read data
    localparam int         ram_regs   = 13;
    localparam logic [3:0] nibble_pad = 4'hF;

    // The 10 Hz enable is divided down to one tick per second
    localparam int                      prescale_count = 10;
    localparam int                      prescale_width = $clog2(prescale_count);
    localparam logic [prescale_width-1:0] prescale_last = prescale_width'(prescale_count - 1);

    // Digit positions of block 0, following the RP5C01 register map
    localparam logic [3:0] reg_sec1   = 4'd0;
    localparam logic [3:0] reg_sec10  = 4'd1;
    localparam logic [3:0] reg_min1   = 4'd2;
    localparam logic [3:0] reg_min10  = 4'd3;
    localparam logic [3:0] reg_hour1  = 4'd4;
    localparam logic [3:0] reg_hour10 = 4'd5;
    localparam logic [3:0] reg_wday   = 4'd6;
    localparam logic [3:0] reg_day1   = 4'd7;
    localparam logic [3:0] reg_day10  = 4'd8;
    localparam logic [3:0] reg_mon1   = 4'd9;
    localparam logic [3:0] reg_mon10  = 4'd10;
    localparam logic [3:0] reg_year1  = 4'd11;
    localparam logic [3:0] reg_year10 = 4'd12;

    // Block 0 as the counter publishes it, one nibble per register
    typedef logic [3:0] time_nibble_t [ram_regs];

endpackage

// File: rtl/rtc_register_file.sv
// RP5C01-style register file; registers E and F ignore writes, RAM contents do not survive power-off
`timescale 1ns/1ps

module rtc_register_file (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req,
    input  logic                      sel_data,
    input  logic [3:0]                wdata,
    input  msx_rtc_pkg::time_nibble_t now,
    output msx_rtc_pkg::time_wr_t     time_wr,
    output logic                      run,
    output logic [3:0]                rdata
);

    // Register address written through the address port
    logic [3:0] addr_q;

    // Mode register with the timer enable in bit 3, spare storage in bit 2 and the block select
    // in bits 1 to 0
    logic [3:0] mode_q;
    logic [1:0] blk;

    // Blocks 1 to 3 hold the alarm block as plain storage and the two RAM blocks
    logic [3:0] ram_q [1:3][msx_rtc_pkg::ram_regs];

    logic wr_addr;
    logic wr_data;
    logic in_block;

    assign blk = mode_q[1:0];
    assign run = mode_q[3];

    // The address port and data port share one strobe and address bit 0 picks between them
    assign wr_addr = req && !sel_data;
    assign wr_data = req && sel_data;

    // Only registers 0 to 12 are banked and 13 is the mode register in every block
    assign in_block = addr_q < 4'(msx_rtc_pkg::ram_regs);

    // Block 0 writes go straight to the counter, which owns those digits
    assign time_wr.valid = wr_data && in_block && (blk == 2'd0);
    assign time_wr.index = addr_q;
    assign time_wr.value = wdata;

    // Address latch and mode register
    always_ff @(posedge clk) begin
        if (rst) begin
            addr_q <= '0;
            mode_q <= msx_rtc_pkg::mode_reset_value;
        end else begin
            if (wr_addr) begin
                addr_q <= wdata;
            end
            if (wr_data && addr_q == msx_rtc_pkg::reg_mode) begin
                mode_q <= wdata;
            end
        end
    end

    // Storage for blocks 1 to 3
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int b = 1; b <= 3; b++) begin
                for (int r = 0; r < msx_rtc_pkg::ram_regs; r++) begin
                    ram_q[b][r] <= '0;
                end
            end
        end else if (wr_data && in_block && blk != 2'd0) begin
            ram_q[blk][addr_q] <= wdata;
        end
    end

    // The read side is combinational so the data port shows the addressed nibble at once
    always_comb begin
        if (addr_q == msx_rtc_pkg::reg_mode) begin
            rdata = mode_q;
        end else if (!in_block) begin
            // Registers E and F
            rdata = msx_rtc_pkg::nibble_pad;
        end else if (blk == 2'd0) begin
            rdata = now[addr_q];
        end else begin
            rdata = ram_q[blk][addr_q];
        end
    end

    // A write aimed at blocks 1 to 3 lands in storage and reads back on the next cycle
    storage_readback: assert property (@(posedge clk) disable iff (rst)
        wr_data && in_block && (blk != 2'd0) |=> rdata == $past(wdata));

endmodule

// File: rtl/rtc_time_counter.sv
// BCD calendar, 24-hour mode only; expects valid BCD on load and writes, no alarm or 1 Hz output
`timescale 1ns/1ps

module rtc_time_counter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      run,
    input  logic                      ce_10hz,
    input  msx_rtc_pkg::rtc_time_t    load_time,
    input  msx_rtc_pkg::time_wr_t     time_wr,
    output msx_rtc_pkg::time_nibble_t now
);

    // Calendar state, two BCD digits per field
    logic [7:0] sec;
    logic [7:0] min;
    logic [7:0] hour;
    logic [7:0] wday;
    logic [7:0] day;
    logic [7:0] month;
    logic [7:0] year;

    // Values the calendar takes if this edge carries a one-second tick
    logic [7:0] sec_n;
    logic [7:0] min_n;
    logic [7:0] hour_n;
    logic [7:0] wday_n;
    logic [7:0] day_n;
    logic [7:0] month_n;
    logic [7:0] year_n;

    logic [msx_rtc_pkg::prescale_width-1:0] presc;
    logic                                   tick;
    logic                                   leap;
    logic [7:0]                             month_days;

    // Adds one to a two-digit BCD value; 99 is handled by the caller
    function automatic logic [7:0] bcd_inc(input logic [7:0] v);
        if (v[3:0] == 4'd9) begin
            return {v[7:4] + 4'd1, 4'd0};
        end
        return {v[7:4], v[3:0] + 4'd1};
    endfunction

    // The prescaler keeps counting while the timer is stopped, only the tick is held back
    assign tick = ce_10hz && run && (presc == msx_rtc_pkg::prescale_last);

    // A two-digit year divisible by four, read straight from the BCD digits
    assign leap = year[4] ? (year[3:0] == 4'd2 || year[3:0] == 4'd6)
                          : (year[3:0] == 4'd0 || year[3:0] == 4'd4 || year[3:0] == 4'd8);

    // Last day of the current month in BCD
    always_comb begin
        case (month)
            8'h02:                      month_days = leap ? 8'h29 : 8'h28;
            8'h04, 8'h06, 8'h09, 8'h11: month_days = 8'h30;
            default:                    month_days = 8'h31;
        endcase
    end

    // Carry chain, every stage only moves when all lower stages wrap
    always_comb begin
        sec_n   = sec;
        min_n   = min;
        hour_n  = hour;
        wday_n  = wday;
        day_n   = day;
        month_n = month;
        year_n  = year;
        if (tick) begin
            sec_n = (sec == 8'h59) ? 8'h00 : bcd_inc(sec);
            if (sec == 8'h59) begin
                min_n = (min == 8'h59) ? 8'h00 : bcd_inc(min);
                if (min == 8'h59) begin
                    hour_n = (hour == 8'h23) ? 8'h00 : bcd_inc(hour);
                    if (hour == 8'h23) begin
                        // Day of week runs 0 to 6 independently of the date
                        wday_n = (wday == 8'h06) ? 8'h00 : wday + 8'd1;
                        day_n  = (day == month_days) ? 8'h01 : bcd_inc(day);
                        if (day == month_days) begin
                            month_n = (month == 8'h12) ? 8'h01 : bcd_inc(month);
                            if (month == 8'h12) begin
                                year_n = (year == 8'h99) ? 8'h00 : bcd_inc(year);
                            end
                        end
                    end
                end
            end
        end
    end

    // Load beats a digit write, and a digit write beats the tick on the same edge
    always_ff @(posedge clk) begin
        if (rst || load_time.update) begin
            sec   <= load_time.sec;
            min   <= load_time.min;
            hour  <= load_time.hour;
            wday  <= load_time.wday;
            day   <= load_time.day;
            month <= load_time.month;
            year  <= load_time.year;
            presc <= '0;
        end else begin
            if (ce_10hz) begin
                presc <= (presc == msx_rtc_pkg::prescale_last) ? '0 : presc + 1'b1;
            end
            if (time_wr.valid) begin
                case (time_wr.index)
                    msx_rtc_pkg::reg_sec1:   sec[3:0]   <= time_wr.value;
                    msx_rtc_pkg::reg_sec10:  sec[7:4]   <= time_wr.value;
                    msx_rtc_pkg::reg_min1:   min[3:0]   <= time_wr.value;
                    msx_rtc_pkg::reg_min10:  min[7:4]   <= time_wr.value;
                    msx_rtc_pkg::reg_hour1:  hour[3:0]  <= time_wr.value;
                    msx_rtc_pkg::reg_hour10: hour[7:4]  <= time_wr.value;
                    msx_rtc_pkg::reg_wday:   wday[3:0]  <= time_wr.value;
                    msx_rtc_pkg::reg_day1:   day[3:0]   <= time_wr.value;
                    msx_rtc_pkg::reg_day10:  day[7:4]   <= time_wr.value;
                    msx_rtc_pkg::reg_mon1:   month[3:0] <= time_wr.value;
                    msx_rtc_pkg::reg_mon10:  month[7:4] <= time_wr.value;
                    msx_rtc_pkg::reg_year1:  year[3:0]  <= time_wr.value;
                    msx_rtc_pkg::reg_year10: year[7:4]  <= time_wr.value;
                    default: ;
                endcase
            end else begin
                sec   <= sec_n;
                min   <= min_n;
                hour  <= hour_n;
                wday  <= wday_n;
                day   <= day_n;
                month <= month_n;
                year  <= year_n;
            end
        end
    end

    // Block 0 as the register file reads it
    always_comb begin
        now[msx_rtc_pkg::reg_sec1]   = sec[3:0];
        now[msx_rtc_pkg::reg_sec10]  = sec[7:4];
        now[msx_rtc_pkg::reg_min1]   = min[3:0];
        now[msx_rtc_pkg::reg_min10]  = min[7:4];
        now[msx_rtc_pkg::reg_hour1]  = hour[3:0];
        now[msx_rtc_pkg::reg_hour10] = hour[7:4];
        now[msx_rtc_pkg::reg_wday]   = wday[3:0];
        now[msx_rtc_pkg::reg_day1]   = day[3:0];
        now[msx_rtc_pkg::reg_day10]  = day[7:4];
        now[msx_rtc_pkg::reg_mon1]   = month[3:0];
        now[msx_rtc_pkg::reg_mon10]  = month[7:4];
        now[msx_rtc_pkg::reg_year1]  = year[3:0];
        now[msx_rtc_pkg::reg_year10] = year[7:4];
    end

    // The clock fields stay in range across loads, writes and carries
    time_in_range: assert property (@(posedge clk)
        !rst |-> (sec < 8'h60) && (min < 8'h60) && (hour < 8'h24));

endmodule

// File: verification/dev_rtc_tb.sv
// Self-checking testbench for dev_rtc; only ports B4/B5 are used and all time digits written stay valid BCD
`timescale 1ns/1ps

module dev_rtc_tb;

    logic                    clk;
    logic                    rst;
    msx_rtc_pkg::cpu_bus_t   bus;
    msx_rtc_pkg::io_device_t io_device;
    logic                    ce_10hz;
    msx_rtc_pkg::rtc_time_t  rtc_time;
    logic [7:0]              data;

    integer seed = 36;
    int     errors;
    int     timeouts;
    int     checks;

    // Model calendar in decimal, ordered sec, min, hour, wday, day, month, year
    int         cal [7];
    int         presc;
    int         ticks;
    int         lost;
    logic [3:0] m_addr;
    logic [3:0] m_mode;
    logic [3:0] m_ram [1:3][13];

    dev_rtc dut0 (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus),
        .io_device (io_device),
        .ce_10hz   (ce_10hz),
        .rtc_time  (rtc_time),
        .data      (data)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [7:0] bcd(int v);
        return 8'((v / 10) * 16 + v % 10);
    endfunction

    function automatic int days_in(int month, int year);
        case (month)
            2:           return (year % 4 == 0) ? 29 : 28;
            4, 6, 9, 11: return 30;
            default:     return 31;
        endcase
    endfunction

    // Register 0..12 to calendar field; the weekday sits alone at register 6
    function automatic int field_of(int i);
        return (i < 6) ? i / 2 : (i == 6) ? 3 : (i + 1) / 2;
    endfunction

    // Tens digits are the odd registers below the weekday and the even ones above it
    function automatic bit is_tens(int i);
        return (i < 6) ? (i % 2 == 1) : (i > 6) && (i % 2 == 0);
    endfunction

    // Port decode as the bus currently stands
    function automatic bit selected();
        return io_device.enable && bus.iorq && !bus.m1
            && ((bus.addr[7:0] & io_device.mask) == io_device.port);
    endfunction

    function automatic void advance_second();
        cal[0]++;
        if (cal[0] == 60) begin
            cal[0] = 0;
            cal[1]++;
        end
        if (cal[1] == 60) begin
            cal[1] = 0;
            cal[2]++;
        end
        if (cal[2] == 24) begin
            cal[2] = 0;
            cal[3] = (cal[3] + 1) % 7;
            cal[4] = (cal[4] == days_in(cal[5], cal[6])) ? 1 : cal[4] + 1;
            // Day 1 again means the month has turned over
            if (cal[4] == 1) begin
                cal[5]++;
            end
        end
        if (cal[5] == 13) begin
            cal[5] = 1;
            cal[6] = (cal[6] + 1) % 100;
        end
    endfunction

    function automatic logic [7:0] expected_data();
        int         v;
        logic [3:0] nib;
        if (m_addr == 4'd13) begin
            nib = m_mode;
        end else if (m_addr > 4'd13) begin
            nib = 4'hF;
        end else if (m_mode[1:0] != 2'd0) begin
            nib = m_ram[m_mode[1:0]][m_addr];
        end else begin
            v   = cal[field_of(m_addr)];
            nib = 4'(is_tens(m_addr) ? v / 10 : v % 10);
        end
        return selected() ? {4'hF, nib} : 8'hFF;
    endfunction

    // Reference model, sees the inputs the DUT samples on the same edge
    always @(posedge clk) begin : model
        bit tick;
        bit wr_hit;
        int f;
        wr_hit = selected() && bus.req && bus.wr;
        if (rst || rtc_time.update) begin
            // Field k of rtc_time sits at bits 8k+8 down to 8k+1, above the update bit
            for (int k = 0; k < 7; k++) begin
                cal[k] = rtc_time[8*k+1 +: 4] + 10 * rtc_time[8*k+5 +: 4];
            end
            presc = 0;
        end else begin
            tick = ce_10hz && m_mode[3] && (presc == msx_rtc_pkg::prescale_count - 1);
            if (ce_10hz) begin
                presc = (presc + 1) % msx_rtc_pkg::prescale_count;
            end
            if (wr_hit && bus.addr[0] && m_addr < 4'd13 && m_mode[1:0] == 2'd0) begin
                f      = field_of(m_addr);
                cal[f] = is_tens(m_addr) ? bus.wdata[3:0] * 10 + cal[f] % 10
                                         : cal[f] / 10 * 10 + bus.wdata[3:0];
                // The digit write takes this edge and the second is dropped
                lost += int'(tick);
            end else if (tick) begin
                advance_second();
                ticks++;
            end
        end
        if (rst) begin
            m_addr = 4'd0;
            m_mode = 4'h8;
            for (int b = 1; b <= 3; b++) begin
                for (int r = 0; r < 13; r++) begin
                    m_ram[b][r] = 4'd0;
                end
            end
        end else if (wr_hit && !bus.addr[0]) begin
            m_addr = bus.wdata[3:0];
        end else if (wr_hit && m_addr == 4'd13) begin
            m_mode = bus.wdata[3:0];
        end else if (wr_hit && m_addr < 4'd13 && m_mode[1:0] != 2'd0) begin
            m_ram[m_mode[1:0]][m_addr] = bus.wdata[3:0];
        end
    end

    // Every cycle out of reset compares the read bus against the model
    always @(negedge clk) begin : monitor
        logic [7:0] exp_data;
        if (!rst) begin
            exp_data = expected_data();
            checks++;
            assert (data === exp_data) else begin
                $display("Mismatch at %0t ns: data %h, expected %h (register %0d, mode %h)",
                         $time, data, exp_data, m_addr, m_mode);
                errors++;
            end
        end
    end

    task automatic drive(input logic [7:0] lo, input logic [3:0] nib, input bit iorq,
                         input bit m1, input bit wr, input bit enable);
        msx_rtc_pkg::cpu_bus_t b;
        b = '{addr: {8'(rand_below(256)), lo}, wdata: {4'(rand_below(16)), nib},
              iorq: iorq, m1: m1, req: 1'b1, wr: wr};
        @(posedge clk);
        bus              <= b;
        io_device.enable <= enable;
        ce_10hz          <= (rand_below(3) == 0);
    endtask

    task automatic write_reg(input int r, input logic [3:0] v);
        drive(8'hB4, 4'(r), 1'b1, 1'b0, 1'b1, 1'b1);
        drive(8'hB5, v, 1'b1, 1'b0, 1'b1, 1'b1);
    endtask

    task automatic read_reg(input int r);
        drive(8'hB4, 4'(r), 1'b1, 1'b0, 1'b1, 1'b1);
        drive(8'hB5, 4'(rand_below(16)), 1'b1, 1'b0, 1'b0, 1'b1);
    endtask

    task automatic read_all();
        for (int r = 0; r < 16; r++) begin
            read_reg(r);
        end
    endtask

    task automatic set_time(input msx_rtc_pkg::rtc_time_t t);
        @(posedge clk);
        rtc_time        <= t;
        rtc_time.update <= 1'b1;
        @(posedge clk);
        rtc_time.update <= 1'b0;
    endtask

    function automatic msx_rtc_pkg::rtc_time_t random_time();
        int y;
        int mo;
        y  = rand_below(100);
        mo = 1 + rand_below(12);
        return '{year: bcd(y), month: bcd(mo), day: bcd(1 + rand_below(days_in(mo, y))),
                 wday: bcd(rand_below(7)), hour: bcd(rand_below(24)),
                 min: bcd(rand_below(60)), sec: bcd(rand_below(60)), update: 1'b0};
    endfunction

    // Digits that keep the time valid whatever the other digit of the field holds
    function automatic logic [3:0] pick_digit(int r);
        case (r)
            1, 3:    return 4'(rand_below(6));
            4:       return 4'(rand_below(4));
            5, 10:   return 4'(rand_below(2));
            6:       return 4'(rand_below(7));
            7:       return 4'(1 + rand_below(8));
            8, 9:    return 4'(1 + rand_below(2));
            default: return 4'(rand_below(10));
        endcase
    endfunction

    task automatic wait_ticks(input int n);
        int target;
        int cycles;
        target = ticks + n;
        cycles = 0;
        while (ticks < target && cycles < n * 200) begin
            read_reg(rand_below(13));
            cycles += 2;
        end
        if (ticks < target) begin
            $display("Timeout: the clock did not advance %0d seconds", n);
            timeouts++;
        end
    endtask

    // Starts at 23:59:5x on the given date so the next seconds ripple through every field
    task automatic boundary(input int y, input int mo, input int d, input int wd);
        set_time('{year: bcd(y), month: bcd(mo), day: bcd(d), wday: bcd(wd), hour: 8'h23,
                   min: 8'h59, sec: bcd(50 + rand_below(10)), update: 1'b0});
        wait_ticks(12);
        read_all();
    endtask

    initial begin : stimulus
        int idx;
        int kind;
        int tries;
        rst       = 1'b1;
        bus       = '0;
        io_device = '{enable: 1'b1, port: 8'hB4, mask: 8'hFE};
        ce_10hz   = 1'b0;
        rtc_time  = random_time();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        // Reset load, then a reload through update
        read_all();
        set_time(random_time());
        read_all();
        boundary(99, 12, 31, 6);
        boundary(24, 2, 28, 3);
        boundary(23, 2, 28, 2);
        boundary(24, 2, 29, 4);
        boundary(24, 4, 30, 1);
        boundary(23, 1, 31, 2);
        // Block 0 digit writes, then more until two have hit a tick edge
        for (int k = 0; k < 60; k++) begin
            idx = rand_below(13);
            write_reg(idx, pick_digit(idx));
            read_reg(idx);
        end
        tries = 0;
        while (lost < 2 && tries < 3000) begin
            idx = rand_below(13);
            write_reg(idx, pick_digit(idx));
            tries++;
        end
        if (lost < 2) begin
            $display("Timeout: no digit write landed on a one-second tick");
            timeouts++;
        end
        // Alarm block and both RAM blocks, with the timer left running
        for (int b = 1; b <= 3; b++) begin
            write_reg(13, 4'(8 + b));
            for (int r = 0; r < 13; r++) begin
                write_reg(r, 4'(rand_below(16)));
            end
            read_all();
        end
        write_reg(14, 4'(rand_below(16)));
        write_reg(15, 4'(rand_below(16)));
        write_reg(13, 4'(rand_below(16)));
        read_all();
        // Wrong port, m1 high, iorq low or enable clear must not reach the device
        for (int k = 0; k < 40; k++) begin
            kind = rand_below(4);
            drive((kind == 0) ? 8'hB4 ^ 8'(2 << rand_below(7)) : 8'hB4 | 8'(rand_below(2)),
                  4'(rand_below(16)), kind != 2, kind == 1, 1'b1, kind != 3);
        end
        read_all();
        // Timer hold under ce_10hz traffic, then resume
        write_reg(13, 4'h0);
        for (int k = 0; k < 100; k++) begin
            read_reg(rand_below(13));
        end
        write_reg(13, 4'h8);
        wait_ticks(3);
        read_all();
        $display("Run complete: %0d checks, %0d mismatches, %0d timeouts",
                 checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
rtl/msx_rtc_pkg.sv
rtl/rtc_time_counter.sv
rtl/rtc_register_file.sv
rtl/dev_rtc.sv
verification/dev_rtc_tb.sv
